//--- Makefile
TOP := ex_stage_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- filelist.f
hw/ex_pkg.sv
hw/ex_issue_router.sv
hw/ex_alu.sv
hw/ex_mult.sv
hw/ex_cdb_arbiter.sv
hw/ex_stage.sv
testbench/ex_stage_tb.sv

//--- hw/ex_alu.sv
// Single-cycle integer ALU.
// Computes the opcode result on the start strobe and holds it in the
// output register with its tag and ROB index until the CDB arbiter
// grants it. Compare opcodes also drive the branch-taken flag.

module ex_alu
	import ex_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  ex_issue_t  op_in,
	input  logic       grant,
	output fu_result_t result,
	output logic       free
);

	logic [DATA_W-1:0] alu_value;
	logic              alu_br;

	////////////////////////////////////////////////////////////
	// Function evaluation
	////////////////////////////////////////////////////////////

	always_comb begin
		alu_value = '0;
		alu_br = 1'b0;
		case (op_in.op)
			ALU_ADDQ:   alu_value = op_in.opa + op_in.opb;
			ALU_SUBQ:   alu_value = op_in.opa - op_in.opb;
			ALU_AND:    alu_value = op_in.opa & op_in.opb;
			ALU_BIS:    alu_value = op_in.opa | op_in.opb;
			ALU_XOR:    alu_value = op_in.opa ^ op_in.opb;
			ALU_SLL:    alu_value = op_in.opa << op_in.opb[5:0];
			ALU_SRL:    alu_value = op_in.opa >> op_in.opb[5:0];
			ALU_CMPEQ: begin
				alu_br = (op_in.opa == op_in.opb);
				alu_value = {{(DATA_W-1){1'b0}}, alu_br};
			end
			ALU_CMPULT: begin
				alu_br = (op_in.opa < op_in.opb);
				alu_value = {{(DATA_W-1){1'b0}}, alu_br};
			end
			// Multiplies never reach this unit
			default: begin
				alu_value = '0;
				alu_br = 1'b0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Held result register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		// A new start wins over the clear from a grant
		if (reset) begin
			result.valid <= 1'b0;
		end else if (start) begin
			result.valid <= 1'b1;
		end else if (grant) begin
			result.valid <= 1'b0;
		end

		if (start) begin
			result.tag <= op_in.pdest;
			result.value <= alu_value;
			result.rob_idx <= op_in.rob_idx;
			result.br_taken <= alu_br;
		end
	end

	// Empty, or leaving on this edge
	assign free = ~result.valid | grant;

endmodule

//--- hw/ex_cdb_arbiter.sv
// Common data bus arbiter.
// Fixed priority with the ALU above the multiplier. At most one held
// result is granted per cycle and driven onto the CDB; a unit that
// loses keeps its result and offers it again next cycle.

module ex_cdb_arbiter
	import ex_pkg::*;
(
	input  fu_result_t alu_result,
	input  fu_result_t mult_result,
	output logic       alu_grant,
	output logic       mult_grant,
	output fu_result_t cdb
);

	////////////////////////////////////////////////////////////
	// Grant
	////////////////////////////////////////////////////////////

	// ALU results never wait
	assign alu_grant = alu_result.valid;

	// Multiplier only on a cycle with no ALU result
	assign mult_grant = mult_result.valid & ~alu_result.valid;

	////////////////////////////////////////////////////////////
	// Bus mux
	////////////////////////////////////////////////////////////

	always_comb begin
		if (alu_grant) begin
			cdb = alu_result;
		end else if (mult_grant) begin
			cdb = mult_result;
		end else begin
			// Idle bus carries an all-zero, invalid result
			cdb = '0;
		end
	end

endmodule

//--- hw/ex_issue_router.sv
// Issue router for the execute stage.
// Classifies the incoming opcode into a unit class, reports whether
// the selected unit can take it, and raises a one-cycle start strobe
// toward that unit when the packet is accepted.

module ex_issue_router
	import ex_pkg::*;
(
	input  ex_issue_t issue,
	input  logic      alu_free,
	input  logic      mult_free,
	output logic      issue_ready,
	output logic      alu_start,
	output logic      mult_start,
	output ex_issue_t fu_issue
);

	ex_class_e unit_class;

	// Multiplies go to the iterative unit, everything else to the ALU
	always_comb begin
		if (!issue.valid) begin
			unit_class = EX_NOOP;
		end else if (issue.op == ALU_MULQ) begin
			unit_class = EX_MULT;
		end else begin
			unit_class = EX_ALU;
		end
	end

	// Ready follows the selected unit; an empty slot is always ready
	always_comb begin
		issue_ready = 1'b1;
		alu_start = 1'b0;
		mult_start = 1'b0;
		case (unit_class)
			EX_ALU: begin
				issue_ready = alu_free;
				alu_start = alu_free;
			end
			EX_MULT: begin
				issue_ready = mult_free;
				mult_start = mult_free;
			end
			default: begin
				issue_ready = 1'b1;
			end
		endcase
	end

	// Packet to the units, qualified by the start strobes
	assign fu_issue = issue;

endmodule

//--- hw/ex_mult.sv
// Iterative 64-bit multiplier.
// Adds one MULT_STEP_W-bit slice of the multiplier per cycle, so the
// low product bits are ready MULT_CYCLES edges after the start strobe.
// The product waits in the held result register until it is granted,
// and no new multiply is taken while it waits.

module ex_mult
	import ex_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  ex_issue_t  op_in,
	input  logic       grant,
	output fu_result_t result,
	output logic       free
);

	typedef enum logic [1:0] {
		MULT_IDLE = 2'b00,
		MULT_BUSY = 2'b01,
		MULT_DONE = 2'b10
	} mult_state_e;

	mult_state_e          state_q;
	logic [MULT_CNT_W-1:0] count_q;

	logic [DATA_W-1:0]    acc_q;
	logic [DATA_W-1:0]    mcand_q;
	logic [DATA_W-1:0]    mplier_q;
	logic [DATA_W-1:0]    value_q;
	logic [PRF_IDX_W-1:0] tag_q;
	logic [ROB_IDX_W-1:0] rob_q;

	logic [DATA_W-1:0]    step_acc;
	logic [DATA_W-1:0]    step_mcand;
	logic [DATA_W-1:0]    step_mplier;
	logic [DATA_W-1:0]    step_slice;
	logic [DATA_W-1:0]    step_sum;
	logic                 last_step;

	////////////////////////////////////////////////////////////
	// Partial product step
	////////////////////////////////////////////////////////////

	// The start edge already does the first slice straight from the packet
	assign step_acc = start ? '0 : acc_q;
	assign step_mcand = start ? op_in.opa : mcand_q;
	assign step_mplier = start ? op_in.opb : mplier_q;
	assign step_slice = {{(DATA_W-MULT_STEP_W){1'b0}}, step_mplier[MULT_STEP_W-1:0]};
	assign step_sum = step_acc + step_mcand * step_slice;

	assign last_step = (state_q == MULT_BUSY) && (count_q == MULT_CNT_W'(MULT_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (start || state_q == MULT_BUSY) begin
			acc_q <= step_sum;
			mcand_q <= step_mcand << MULT_STEP_W;
			mplier_q <= step_mplier >> MULT_STEP_W;
		end
		if (start) begin
			tag_q <= op_in.pdest;
			rob_q <= op_in.rob_idx;
		end
		if (last_step) begin
			value_q <= step_sum;
		end
	end

	////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= MULT_IDLE;
			count_q <= '0;
		end else begin
			case (state_q)
				MULT_IDLE: begin
					if (start) begin
						state_q <= MULT_BUSY;
						count_q <= MULT_CNT_W'(1);
					end
				end
				MULT_BUSY: begin
					count_q <= count_q + 1'b1;
					if (last_step) begin
						state_q <= MULT_DONE;
					end
				end
				MULT_DONE: begin
					// Back to back multiply when the held result leaves
					if (grant && start) begin
						state_q <= MULT_BUSY;
						count_q <= MULT_CNT_W'(1);
					end else if (grant) begin
						state_q <= MULT_IDLE;
					end
				end
				default: begin
					state_q <= MULT_IDLE;
				end
			endcase
		end
	end

	assign free = (state_q == MULT_IDLE) || (state_q == MULT_DONE && grant);

	assign result = '{
		valid: (state_q == MULT_DONE),
		tag: tag_q,
		value: value_q,
		rob_idx: rob_q,
		br_taken: 1'b0
	};

endmodule

//--- hw/ex_pkg.sv
// Shared definitions for the execute-to-complete stage.
// Holds the datapath widths, the multiplier iteration count, the
// opcode and unit-class encodings, and the issue and result packets.
// Every stage module imports this package with a wildcard import.

package ex_pkg;

	////////////////////////////////////////////////////////////
	// Widths and timing
	////////////////////////////////////////////////////////////

	// Operand and result width
	localparam int DATA_W = 64;

	// Physical destination tag and ROB index widths
	localparam int PRF_IDX_W = 6;
	localparam int ROB_IDX_W = 5;

	// Multiplier iterations, one partial product slice per cycle
	localparam int MULT_CYCLES = 8;
	localparam int MULT_STEP_W = DATA_W / MULT_CYCLES;
	localparam int MULT_CNT_W = $clog2(MULT_CYCLES);

	////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////

	// ALU function codes, sparse as in the decoder
	typedef enum logic [4:0] {
		ALU_ADDQ   = 5'h00,
		ALU_SUBQ   = 5'h01,
		ALU_AND    = 5'h02,
		ALU_BIS    = 5'h04,
		ALU_XOR    = 5'h06,
		ALU_SRL    = 5'h08,
		ALU_SLL    = 5'h09,
		ALU_MULQ   = 5'h0b,
		ALU_CMPEQ  = 5'h0c,
		ALU_CMPULT = 5'h0f
	} alu_op_e;

	// Functional unit class picked by the router
	typedef enum logic [1:0] {
		EX_NOOP = 2'b00,
		EX_ALU  = 2'b01,
		EX_MULT = 2'b10
	} ex_class_e;

	////////////////////////////////////////////////////////////
	// Packets
	////////////////////////////////////////////////////////////

	// One issued instruction with its source values
	typedef struct packed {
		logic                 valid;
		alu_op_e              op;
		logic [DATA_W-1:0]    opa;
		logic [DATA_W-1:0]    opb;
		logic [PRF_IDX_W-1:0] pdest;
		logic [ROB_IDX_W-1:0] rob_idx;
	} ex_issue_t;

	// Finished result, same shape on unit outputs and on the CDB
	typedef struct packed {
		logic                 valid;
		logic [PRF_IDX_W-1:0] tag;
		logic [DATA_W-1:0]    value;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic                 br_taken;
	} fu_result_t;

endpackage

//--- hw/ex_stage.sv
// Top of the execute-to-complete stage.
// Takes one issue packet per cycle, routes it to the ALU or the
// multiplier, and puts at most one finished result per cycle on the
// CDB. The free levels go back to the issue queue.

module ex_stage
	import ex_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  ex_issue_t  issue,
	output logic       issue_ready,
	output fu_result_t cdb,
	output logic       alu_free,
	output logic       mult_free
);

	ex_issue_t  fu_issue;
	logic       alu_start;
	logic       mult_start;
	logic       alu_grant;
	logic       mult_grant;
	fu_result_t alu_result;
	fu_result_t mult_result;

	ex_issue_router u_router (
		.issue       (issue),
		.alu_free    (alu_free),
		.mult_free   (mult_free),
		.issue_ready (issue_ready),
		.alu_start   (alu_start),
		.mult_start  (mult_start),
		.fu_issue    (fu_issue)
	);

	ex_alu u_alu (
		.clk    (clk),
		.reset  (reset),
		.start  (alu_start),
		.op_in  (fu_issue),
		.grant  (alu_grant),
		.result (alu_result),
		.free   (alu_free)
	);

	ex_mult u_mult (
		.clk    (clk),
		.reset  (reset),
		.start  (mult_start),
		.op_in  (fu_issue),
		.grant  (mult_grant),
		.result (mult_result),
		.free   (mult_free)
	);

	ex_cdb_arbiter u_arbiter (
		.alu_result  (alu_result),
		.mult_result (mult_result),
		.alu_grant   (alu_grant),
		.mult_grant  (mult_grant),
		.cdb         (cdb)
	);

endmodule

//--- testbench/ex_stage_tb.sv
// Directed testbench for the execute-to-complete stage.
// Drives issue packets into ex_stage and checks the CDB, the ready
// level and the unit free levels against a reference model of the
// opcode rules and the fixed ALU and multiplier latencies.

module ex_stage_tb
	import ex_pkg::*;
;

	localparam int CLK_PERIOD = 4;
	localparam int NUM_TESTS = 6;
	localparam alu_op_e ALU_OPS [9] = '{ALU_ADDQ, ALU_SUBQ, ALU_AND, ALU_BIS, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_CMPEQ, ALU_CMPULT};

	logic       clk;
	logic       reset;
	ex_issue_t  issue;
	logic       issue_ready;
	fu_result_t cdb;
	logic       alu_free;
	logic       mult_free;

	int errors = 0;
	int pass_count = 0;
	int fail_count = 0;

	ex_stage u_ex_stage (
		.clk         (clk),
		.reset       (reset),
		.issue       (issue),
		.issue_ready (issue_ready),
		.cdb         (cdb),
		.alu_free    (alu_free),
		.mult_free   (mult_free)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#((NUM_TESTS * 40 + 200) * CLK_PERIOD);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Helpers and reference model
	////////////////////////////////////////////////////////////

	task automatic check_result(input string name, input fu_result_t got, input fu_result_t exp);
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	// Inputs change 1 time unit after the rising edge
	task automatic advance_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic drive_issue(input logic valid, input alu_op_e op,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
		input logic [PRF_IDX_W-1:0] tag, input logic [ROB_IDX_W-1:0] rob);
		issue.valid = valid;
		issue.op = op;
		issue.opa = a;
		issue.opb = b;
		issue.pdest = tag;
		issue.rob_idx = rob;
	endtask

	task automatic clear_issue();
		issue = '0;
	endtask

	function automatic logic [DATA_W-1:0] rand64();
		return {$urandom, $urandom};
	endfunction

	// Expected CDB packet from the opcode rules
	function automatic fu_result_t alu_expect(input alu_op_e op, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, input logic [PRF_IDX_W-1:0] tag,
		input logic [ROB_IDX_W-1:0] rob);
		fu_result_t r;
		logic       br;
		br = 1'b0;
		r = '0;
		case (op)
			ALU_ADDQ:   r.value = a + b;
			ALU_SUBQ:   r.value = a - b;
			ALU_AND:    r.value = a & b;
			ALU_BIS:    r.value = a | b;
			ALU_XOR:    r.value = a ^ b;
			ALU_SLL:    r.value = a << b[5:0];
			ALU_SRL:    r.value = a >> b[5:0];
			ALU_CMPEQ:  br = (a == b);
			ALU_CMPULT: br = (a < b);
			ALU_MULQ:   r.value = a * b;
			default:    r.value = '0;
		endcase
		if (op == ALU_CMPEQ || op == ALU_CMPULT) begin
			r.value = DATA_W'(br);
		end
		r.valid = 1'b1;
		r.tag = tag;
		r.rob_idx = rob;
		r.br_taken = br;
		return r;
	endfunction

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			pass_count++;
			$display("%s: ok", name);
		end else begin
			fail_count++;
			$display("%s: %0d errors", name, errors - errs_before);
		end
	endtask

	// One ALU op alone; result expected exactly one cycle later
	task automatic run_alu_op(input alu_op_e op, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, input logic [PRF_IDX_W-1:0] tag);
		logic [ROB_IDX_W-1:0] rob;
		rob = ROB_IDX_W'($urandom);
		drive_issue(1'b1, op, a, b, tag, rob);
		@(negedge clk);
		check_bit("issue_ready", issue_ready, 1'b1);
		check_bit("cdb.valid", cdb.valid, 1'b0);
		advance_cycle();
		clear_issue();
		@(negedge clk);
		check_result("cdb", cdb, alu_expect(op, a, b, tag, rob));
		advance_cycle();
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic reset_test();
		int errs;
		errs = errors;
		@(negedge clk);
		check_bit("cdb.valid", cdb.valid, 1'b0);
		check_bit("alu_free", alu_free, 1'b1);
		check_bit("mult_free", mult_free, 1'b1);
		check_bit("issue_ready", issue_ready, 1'b1);
		advance_cycle();
		report_test("reset_test", errs);
	endtask

	task automatic alu_ops_test();
		int errs;
		errs = errors;
		for (int i = 0; i < 9; i++) begin
			run_alu_op(ALU_OPS[i], rand64(), rand64(), PRF_IDX_W'(i + 1));
		end
		report_test("alu_ops_test", errs);
	endtask

	task automatic compare_test();
		int errs;
		logic [DATA_W-1:0] lo;
		logic [DATA_W-1:0] hi;
		errs = errors;
		// Top bit clear in lo and set in hi keeps lo below hi
		lo = rand64() >> 1;
		hi = lo | {1'b1, {(DATA_W-1){1'b0}}};
		run_alu_op(ALU_CMPEQ, lo, lo, 6'd20);
		run_alu_op(ALU_CMPEQ, lo, hi, 6'd21);
		run_alu_op(ALU_CMPEQ, hi, lo, 6'd22);
		run_alu_op(ALU_CMPULT, lo, lo, 6'd23);
		run_alu_op(ALU_CMPULT, lo, hi, 6'd24);
		run_alu_op(ALU_CMPULT, hi, lo, 6'd25);
		report_test("compare_test", errs);
	endtask

	task automatic mult_test();
		int         errs;
		int         k;
		bit         seen;
		fu_result_t mult_exp;
		fu_result_t alu_exp;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		errs = errors;
		a = rand64();
		b = rand64();
		mult_exp = alu_expect(ALU_MULQ, a, b, 6'd40, 5'd7);
		alu_exp = alu_expect(ALU_ADDQ, b, a, 6'd42, 5'd8);
		drive_issue(1'b1, ALU_MULQ, a, b, 6'd40, 5'd7);
		@(negedge clk);
		check_bit("issue_ready", issue_ready, 1'b1);
		advance_cycle();
		seen = 0;
		k = 0;
		while (!seen && k < MULT_CYCLES + 4) begin
			k++;
			// An ALU op is still taken while the multiplier runs
			if (k == 2) begin
				drive_issue(1'b1, ALU_ADDQ, b, a, 6'd42, 5'd8);
			end else if (k < MULT_CYCLES) begin
				drive_issue(1'b1, ALU_MULQ, b, a, 6'd41, 5'd9);
			end else begin
				clear_issue();
			end
			@(negedge clk);
			if (cdb.valid && cdb.tag == mult_exp.tag) begin
				seen = 1;
				check_result("cdb", cdb, mult_exp);
				check_bit("mult_free", mult_free, 1'b1);
				if (k != MULT_CYCLES) begin
					errors++;
					$display("Multiply took %0d cycles instead of %0d", k, MULT_CYCLES);
				end
			end else begin
				check_bit("mult_free", mult_free, 1'b0);
				if (k == 2) begin
					check_bit("issue_ready", issue_ready, 1'b1);
				end else if (k < MULT_CYCLES) begin
					check_bit("issue_ready", issue_ready, 1'b0);
				end
				if (k == 3) begin
					check_result("cdb", cdb, alu_exp);
				end else begin
					check_bit("cdb.valid", cdb.valid, 1'b0);
				end
			end
			advance_cycle();
		end
		if (!seen) begin
			errors++;
			$display("Multiply result never reached the CDB");
		end
		clear_issue();
		@(negedge clk);
		check_bit("cdb.valid", cdb.valid, 1'b0);
		check_bit("mult_free", mult_free, 1'b1);
		advance_cycle();
		report_test("mult_test", errs);
	endtask

	// ALU results cover the multiply completion cycle and two after it
	task automatic backpressure_test();
		int         errs;
		fu_result_t mult_exp;
		fu_result_t alu_prev;
		fu_result_t alu_next;
		alu_op_e    op;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		errs = errors;
		a = rand64();
		b = rand64();
		mult_exp = alu_expect(ALU_MULQ, a, b, 6'd30, 5'd3);
		drive_issue(1'b1, ALU_MULQ, a, b, 6'd30, 5'd3);
		advance_cycle();
		alu_prev = '0;
		for (int k = 1; k <= MULT_CYCLES + 3; k++) begin
			alu_next = '0;
			if (k <= MULT_CYCLES + 1) begin
				op = (k % 2 == 1) ? ALU_ADDQ : ALU_XOR;
				a = rand64();
				b = rand64();
				alu_next = alu_expect(op, a, b, PRF_IDX_W'(k), ROB_IDX_W'(k));
				drive_issue(1'b1, op, a, b, PRF_IDX_W'(k), ROB_IDX_W'(k));
			end else begin
				clear_issue();
			end
			@(negedge clk);
			if (k <= MULT_CYCLES + 1) begin
				check_bit("issue_ready", issue_ready, 1'b1);
			end
			if (k == MULT_CYCLES + 3) begin
				check_result("cdb", cdb, mult_exp);
				check_bit("mult_free", mult_free, 1'b1);
			end else begin
				check_result("cdb", cdb, alu_prev);
				check_bit("mult_free", mult_free, 1'b0);
			end
			alu_prev = alu_next;
			advance_cycle();
		end
		@(negedge clk);
		check_bit("cdb.valid", cdb.valid, 1'b0);
		advance_cycle();
		report_test("backpressure_test", errs);
	endtask

	task automatic ignore_test();
		int         errs;
		int         results;
		fu_result_t mult_exp;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		errs = errors;
		results = 0;
		a = rand64();
		b = rand64();
		mult_exp = alu_expect(ALU_MULQ, a, b, 6'd50, 5'd12);
		drive_issue(1'b1, ALU_MULQ, a, b, 6'd50, 5'd12);
		advance_cycle();
		for (int k = 1; k <= 2 * MULT_CYCLES + 2; k++) begin
			// Second multiply while busy, then empty slots with valid low
			if (k < MULT_CYCLES) begin
				drive_issue(1'b1, ALU_MULQ, b, a, 6'd51, 5'd13);
			end else begin
				drive_issue(1'b0, ALU_ADDQ, a, b, 6'd52, 5'd14);
			end
			@(negedge clk);
			check_bit("issue_ready", issue_ready, k >= MULT_CYCLES);
			if (cdb.valid) begin
				results++;
				check_result("cdb", cdb, mult_exp);
			end
			advance_cycle();
		end
		clear_issue();
		if (results != 1) begin
			errors++;
			$display("Expected one multiply result on the CDB, saw %0d", results);
		end
		report_test("ignore_test", errs);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'haf50b946));
		reset = 1'b1;
		clear_issue();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		reset_test();
		alu_ops_test();
		compare_test();
		mult_test();
		backpressure_test();
		ignore_test();

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
